/* common/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	localparam int CACHELINE_SIZE_BITS = 1024;
	localparam int HALF_LINE_BITS = 512;
	localparam int VERTEX_SIZE_BITS = 128;
	localparam int VERTICES_PER_LINE = 8;
	localparam int CACHELINE_BYTES = 128;

	typedef logic [63:0] address_t;
	typedef logic [31:0] vertex_index_t;
	typedef logic [7:0] line_offset_t;
	typedef logic [7:0] shift_count_t;
	typedef logic [3:0] struct_tag_t;
	typedef logic [CACHELINE_SIZE_BITS-1:0] cacheline_t;
	typedef logic [HALF_LINE_BITS-1:0] half_line_t;
	typedef logic [63:0] degree_sum_t;

	localparam struct_tag_t VERTEX_STRUCT_ID = 4'h5;

	// id sits in the top bits, edges_offset in the low 64-bit word
	typedef struct packed {
		logic [31:0] id;
		logic [31:0] degree;
		logic [63:0] edges_offset;
	} vertex_t;

	typedef struct packed {
		logic valid;
		address_t address;
		struct_tag_t vertex_struct;
		line_offset_t cacheline_offset;
		shift_count_t shift_limit;
	} read_cmd_t;

	typedef struct packed {
		logic valid;
		read_cmd_t cmd;
		half_line_t data;
	} read_data_t;

	typedef struct packed {
		logic valid;
		struct_tag_t vertex_struct;
	} read_response_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_LINE,
		DONE
	} fetch_state_t;

	// host writes each 64-bit word big-endian
	function automatic cacheline_t swap_endianness_line(input cacheline_t line);
		cacheline_t swapped;
		for (int w = 0; w < CACHELINE_SIZE_BITS / 64; w++) begin
			for (int b = 0; b < 8; b++) begin
				swapped[w*64 + b*8 +: 8] = line[w*64 + (7-b)*8 +: 8];
			end
		end
		return swapped;
	endfunction

	// slot 0 is the output end, so a seek drops the low slots
	function automatic cacheline_t seek_cacheline(input line_offset_t offset, input cacheline_t line);
		return line >> (int'(offset) * VERTEX_SIZE_BITS);
	endfunction

endpackage

`default_nettype wire

/* rtl/cu_vertex_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_fetch import cu_pkg::*; (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input logic start,
	input vertex_index_t first_vertex,
	input vertex_index_t vertex_count,
	input address_t base_address,
	input logic line_done,
	input vertex_index_t vertices_seen,
	output read_cmd_t read_cmd,
	output logic done
);

	fetch_state_t state;
	vertex_index_t next_vertex;
	vertex_index_t remaining;
	vertex_index_t total;
	address_t base;

	logic accepting;
	logic issue;
	vertex_index_t cur_vertex;
	vertex_index_t cur_remaining;
	vertex_index_t room;
	vertex_index_t take;
	address_t cur_base;
	address_t cur_address;
	line_offset_t cur_offset;

	// a new range is taken straight from the inputs, later lines from the held values
	assign accepting = (state == IDLE) || (state == DONE);
	assign cur_vertex = accepting ? first_vertex : next_vertex;
	assign cur_remaining = accepting ? vertex_count : remaining;
	assign cur_base = accepting ? base_address : base;

	assign cur_offset = line_offset_t'(cur_vertex % VERTICES_PER_LINE);
	assign room = vertex_index_t'(VERTICES_PER_LINE) - vertex_index_t'(cur_offset);
	assign take = (cur_remaining < room) ? cur_remaining : room;
	assign cur_address = cur_base
		+ address_t'(cur_vertex / VERTICES_PER_LINE) * address_t'(CACHELINE_BYTES);

	assign issue = (accepting && start && vertex_count != '0)
		|| (state == WAIT_LINE && line_done && remaining != '0);

	assign done = (state == DONE);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
			read_cmd <= '0;
			next_vertex <= '0;
			remaining <= '0;
			total <= '0;
			base <= '0;
		end else if (!enabled) begin
			state <= IDLE;
			read_cmd <= '0;
			next_vertex <= '0;
			remaining <= '0;
			total <= '0;
			base <= '0;
		end else begin
			case (state)
				IDLE, DONE: begin
					if (start) begin
						total <= vertex_count;
						base <= base_address;
						remaining <= '0;
						state <= WAIT_LINE;
					end
				end
				ISSUE: begin
					read_cmd.valid <= 1'b0;
					state <= WAIT_LINE;
				end
				WAIT_LINE: begin
					if (remaining == '0 && vertices_seen == total)
						state <= DONE;
				end
				default: state <= IDLE;
			endcase

			// address, offset and limit stay put until the next line is issued
			if (issue) begin
				read_cmd <= '{valid: 1'b1, address: cur_address,
					vertex_struct: VERTEX_STRUCT_ID, cacheline_offset: cur_offset,
					shift_limit: shift_count_t'(take)};
				next_vertex <= cur_vertex + take;
				remaining <= cur_remaining - take;
				state <= ISSUE;
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) read_cmd.valid |-> state == ISSUE)
		else $error("read command valid outside ISSUE");

endmodule

`default_nettype wire

/* cu_cacheline_stream/cu_cacheline_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_cacheline_stream import cu_pkg::*; (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input read_data_t read_data_0_in,
	input read_data_t read_data_1_in,
	input read_response_t read_response_in,
	input logic fill,
	input shift_count_t shift_limit,
	output cacheline_t cacheline,
	output logic cacheline_ready,
	output logic line_done
);

	shift_count_t shift_counter;
	shift_count_t next_count;
	line_offset_t shift_seek;
	logic seek_flag;

	logic half_0_hit;
	logic half_1_hit;
	logic response_hit;
	logic last_shift;

	// foreign tags are ignored
	assign half_0_hit = read_data_0_in.valid
		&& (read_data_0_in.cmd.vertex_struct == VERTEX_STRUCT_ID);
	assign half_1_hit = read_data_1_in.valid
		&& (read_data_1_in.cmd.vertex_struct == VERTEX_STRUCT_ID);
	assign response_hit = read_response_in.valid
		&& (read_response_in.vertex_struct == VERTEX_STRUCT_ID);

	assign next_count = shift_counter + shift_count_t'(1);
	assign last_shift = (next_count == shift_limit);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cacheline <= '0;
			cacheline_ready <= 1'b0;
			line_done <= 1'b0;
			shift_counter <= '0;
			shift_seek <= '0;
			seek_flag <= 1'b0;
		end else if (!enabled) begin
			cacheline <= '0;
			cacheline_ready <= 1'b0;
			line_done <= 1'b0;
			shift_counter <= '0;
			shift_seek <= '0;
			seek_flag <= 1'b0;
		end else begin
			line_done <= 1'b0;

			// each half brings its own command's offset
			if (half_0_hit) begin
				cacheline[HALF_LINE_BITS-1:0] <= read_data_0_in.data;
				shift_seek <= read_data_0_in.cmd.cacheline_offset;
			end
			if (half_1_hit) begin
				cacheline[CACHELINE_SIZE_BITS-1:HALF_LINE_BITS] <= read_data_1_in.data;
				shift_seek <= read_data_1_in.cmd.cacheline_offset;
			end

			if (response_hit) begin
				cacheline <= swap_endianness_line(cacheline);
				seek_flag <= 1'b1;
			end

			if (seek_flag) begin
				cacheline <= seek_cacheline(shift_seek, cacheline);
				cacheline_ready <= 1'b1;
				seek_flag <= 1'b0;
				shift_seek <= '0;
			end

			// line empties on the cycle the final vertex goes out
			if (cacheline_ready && fill) begin
				if (last_shift) begin
					cacheline <= '0;
					cacheline_ready <= 1'b0;
					shift_counter <= '0;
					line_done <= 1'b1;
				end else begin
					cacheline <= cacheline >> VERTEX_SIZE_BITS;
					shift_counter <= next_count;
				end
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		cacheline_ready |-> (shift_limit >= 1 && shift_limit <= VERTICES_PER_LINE))
		else $error("shift limit %0d out of range with line ready", shift_limit);

	assert property (@(posedge clock) disable iff (!rstn) shift_counter <= shift_limit)
		else $error("shift counter %0d beyond limit %0d", shift_counter, shift_limit);

endmodule

`default_nettype wire

/* rtl/cu_vertex_drain.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_drain import cu_pkg::*; (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input cacheline_t cacheline,
	input logic cacheline_ready,
	input logic start,
	output logic fill,
	output vertex_t vertex_out,
	output logic vertex_valid,
	output degree_sum_t degree_sum,
	output vertex_index_t vertices_seen
);

	vertex_t head;

	// slot 0 of the line is the next vertex out
	assign head = vertex_t'(cacheline[VERTEX_SIZE_BITS-1:0]);

	// no back-pressure so every offered vertex is taken
	assign fill = cacheline_ready;

	always_ff @(posedge clock) begin
		if (fill)
			vertex_out <= head;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_valid <= 1'b0;
			degree_sum <= '0;
			vertices_seen <= '0;
		end else if (!enabled) begin
			vertex_valid <= 1'b0;
			degree_sum <= '0;
			vertices_seen <= '0;
		end else begin
			vertex_valid <= fill;
			if (start) begin
				degree_sum <= '0;
				vertices_seen <= '0;
			end else if (fill) begin
				degree_sum <= degree_sum + degree_sum_t'(head.degree);
				vertices_seen <= vertices_seen + vertex_index_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/cu_vertex_stream.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_stream import cu_pkg::*; (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input logic start,
	input vertex_index_t first_vertex,
	input vertex_index_t vertex_count,
	input address_t base_address,
	input read_data_t read_data_0,
	input read_data_t read_data_1,
	input read_response_t read_response,
	output read_cmd_t read_cmd,
	output vertex_t vertex_out,
	output logic vertex_valid,
	output degree_sum_t degree_sum,
	output vertex_index_t vertices_seen,
	output logic done
);

	cacheline_t line;
	logic line_ready;
	logic line_done;
	logic fill;

	cu_vertex_fetch cu_vertex_fetch_inst (
		.clock(clock),
		.rstn(rstn),
		.enabled(enabled),
		.start(start),
		.first_vertex(first_vertex),
		.vertex_count(vertex_count),
		.base_address(base_address),
		.line_done(line_done),
		.vertices_seen(vertices_seen),
		.read_cmd(read_cmd),
		.done(done)
	);

	// the fetch holds the current line's limit on read_cmd
	cu_cacheline_stream cu_cacheline_stream_inst (
		.clock(clock),
		.rstn(rstn),
		.enabled(enabled),
		.read_data_0_in(read_data_0),
		.read_data_1_in(read_data_1),
		.read_response_in(read_response),
		.fill(fill),
		.shift_limit(read_cmd.shift_limit),
		.cacheline(line),
		.cacheline_ready(line_ready),
		.line_done(line_done)
	);

	cu_vertex_drain cu_vertex_drain_inst (
		.clock(clock),
		.rstn(rstn),
		.enabled(enabled),
		.cacheline(line),
		.cacheline_ready(line_ready),
		.start(start),
		.fill(fill),
		.vertex_out(vertex_out),
		.vertex_valid(vertex_valid),
		.degree_sum(degree_sum),
		.vertices_seen(vertices_seen)
	);

endmodule

`default_nettype wire

/* test/cu_vertex_stream_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_stream_tb import cu_pkg::*; ();

	localparam logic [31:0] RANDOM_SEED = 32'h8486_48cd;
	localparam struct_tag_t FOREIGN_TAG = ~VERTEX_STRUCT_ID;

	logic clock = 1'b0;
	logic rstn;
	logic enabled;
	logic start;
	vertex_index_t first_vertex;
	vertex_index_t vertex_count;
	address_t base_address;
	read_data_t read_data_0;
	read_data_t read_data_1;
	read_response_t read_response;
	read_cmd_t read_cmd;
	vertex_t vertex_out;
	logic vertex_valid;
	degree_sum_t degree_sum;
	vertex_index_t vertices_seen;
	logic done;

	logic [31:0] rng;
	logic inject_foreign;
	int transfer_id;
	vertex_index_t expect_first;
	vertex_index_t expect_count;
	int received;

	cu_vertex_stream cu_vertex_stream_inst (
		.clock(clock),
		.rstn(rstn),
		.enabled(enabled),
		.start(start),
		.first_vertex(first_vertex),
		.vertex_count(vertex_count),
		.base_address(base_address),
		.read_data_0(read_data_0),
		.read_data_1(read_data_1),
		.read_response(read_response),
		.read_cmd(read_cmd),
		.vertex_out(vertex_out),
		.vertex_valid(vertex_valid),
		.degree_sum(degree_sum),
		.vertices_seen(vertices_seen),
		.done(done)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic vertex_t expected_vertex(input vertex_index_t idx);
		vertex_t v;
		v.id = idx;
		v.degree = xorshift32(idx);
		v.edges_offset = {30'b0, idx, 2'b00};
		return v;
	endfunction

	function automatic degree_sum_t expected_degree_sum(input vertex_index_t first,
		input vertex_index_t count);
		degree_sum_t sum;
		sum = '0;
		for (vertex_index_t i = 0; i < count; i++) begin
			sum = sum + degree_sum_t'(xorshift32(first + i));
		end
		return sum;
	endfunction

	function automatic logic [63:0] big_endian_word(input logic [63:0] word);
		logic [63:0] swapped;
		for (int b = 0; b < 8; b++) begin
			swapped[b*8 +: 8] = word[(7-b)*8 +: 8];
		end
		return swapped;
	endfunction

	// memory image of the line at this address with records 16 bytes apart
	function automatic cacheline_t memory_line(input address_t address, input address_t base);
		cacheline_t line;
		address_t line_index;
		vertex_index_t idx;
		line_index = (address - base) / address_t'(CACHELINE_BYTES);
		for (int s = 0; s < VERTICES_PER_LINE; s++) begin
			idx = vertex_index_t'(line_index * 8) + vertex_index_t'(s);
			line[s*128 +: 64] = big_endian_word({30'b0, idx, 2'b00});
			line[s*128 + 64 +: 64] = big_endian_word({idx, xorshift32(idx)});
		end
		return line;
	endfunction

	task automatic stop_with_failure();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] expected);
		$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected);
		stop_with_failure();
	endtask

	task automatic report_problem(input string what);
		$display("%s", what);
		stop_with_failure();
	endtask

	// step code 1 is half 0, 2 half 1, 3 both halves, 4 response, 5 foreign half and 6 foreign response
	task automatic serve_line(input read_cmd_t cmd);
		cacheline_t line;
		read_cmd_t foreign_cmd;
		int steps[$];
		int delay;
		int order;
		line = memory_line(cmd.address, base_address);
		foreign_cmd = cmd;
		foreign_cmd.vertex_struct = FOREIGN_TAG;
		rng = xorshift32(rng);
		delay = 1 + int'(rng % 6);
		rng = xorshift32(rng);
		order = int'(rng % 3);
		repeat (delay - 1) steps.push_back(0);
		if (order == 0) begin
			steps.push_back(1);
			steps.push_back(2);
		end else if (order == 1) begin
			steps.push_back(2);
			steps.push_back(1);
		end else begin
			steps.push_back(3);
		end
		// a foreign half after the real ones would overwrite half 1 if it were taken
		if (inject_foreign) begin
			steps.push_back(5);
			steps.push_back(6);
		end
		steps.push_back(4);
		foreach (steps[i]) begin
			@(negedge clock);
			read_data_0 = '0;
			read_data_1 = '0;
			read_response = '0;
			if (!enabled)
				break;
			if (steps[i] == 1 || steps[i] == 3)
				read_data_0 = '{valid: 1'b1, cmd: cmd, data: line[HALF_LINE_BITS-1:0]};
			if (steps[i] == 2 || steps[i] == 3)
				read_data_1 = '{valid: 1'b1, cmd: cmd,
					data: line[CACHELINE_SIZE_BITS-1:HALF_LINE_BITS]};
			if (steps[i] == 4)
				read_response = '{valid: 1'b1, vertex_struct: cmd.vertex_struct};
			if (steps[i] == 5)
				read_data_1 = '{valid: 1'b1, cmd: foreign_cmd, data: {16{32'hdead_beef}}};
			if (steps[i] == 6)
				read_response = '{valid: 1'b1, vertex_struct: FOREIGN_TAG};
		end
	endtask

	// memory model
	initial begin
		read_data_0 = '0;
		read_data_1 = '0;
		read_response = '0;
		rng = RANDOM_SEED;
		forever begin
			@(negedge clock);
			read_data_0 = '0;
			read_data_1 = '0;
			read_response = '0;
			if (read_cmd.valid && enabled)
				serve_line(read_cmd);
		end
	end

	// comparing process that counts the vertices of the current transfer
	initial begin
		int seen_id;
		vertex_t expected;
		seen_id = 0;
		received = 0;
		forever begin
			@(negedge clock);
			if (transfer_id != seen_id) begin
				seen_id = transfer_id;
				received = 0;
			end
			if (vertex_valid) begin
				assert (received < int'(expect_count))
					else report_problem("vertex_valid rose after the whole range was seen");
				expected = expected_vertex(expect_first + vertex_index_t'(received));
				assert (vertex_out.id == expected.id)
					else report_mismatch("vertex_out.id", 128'(vertex_out.id), 128'(expected.id));
				assert (vertex_out.degree == expected.degree)
					else report_mismatch("vertex_out.degree", 128'(vertex_out.degree),
						128'(expected.degree));
				assert (vertex_out.edges_offset == expected.edges_offset)
					else report_mismatch("vertex_out.edges_offset",
						128'(vertex_out.edges_offset), 128'(expected.edges_offset));
				received++;
			end
		end
	end

	task automatic check_idle_outputs();
		assert (!read_cmd.valid)
			else report_mismatch("read_cmd.valid", 128'(read_cmd.valid), 128'(0));
		assert (!vertex_valid)
			else report_mismatch("vertex_valid", 128'(vertex_valid), 128'(0));
		assert (!done)
			else report_mismatch("done", 128'(done), 128'(0));
	endtask

	task automatic launch(input vertex_index_t first, input vertex_index_t count);
		@(negedge clock);
		first_vertex = first;
		vertex_count = count;
		expect_first = first;
		expect_count = count;
		transfer_id++;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		assert (vertices_seen == '0)
			else report_mismatch("vertices_seen", 128'(vertices_seen), 128'(0));
		assert (degree_sum == '0)
			else report_mismatch("degree_sum", 128'(degree_sum), 128'(0));
	endtask

	task automatic wait_for_vertices(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (received < count) begin
			@(negedge clock);
			cycles++;
			if (cycles > limit)
				report_problem("timed out waiting for vertex_valid");
		end
	endtask

	task automatic wait_for_done(input int limit);
		int cycles;
		cycles = 0;
		while (!done) begin
			@(negedge clock);
			cycles++;
			if (cycles > limit)
				report_problem("timed out waiting for done to rise");
		end
	endtask

	task automatic run_transfer(input vertex_index_t first, input vertex_index_t count);
		degree_sum_t expected_sum;
		launch(first, count);
		wait_for_done(600);
		expected_sum = expected_degree_sum(first, count);
		assert (received == int'(count))
			else report_mismatch("vertex_valid count", 128'(received), 128'(count));
		assert (vertices_seen == count)
			else report_mismatch("vertices_seen", 128'(vertices_seen), 128'(count));
		assert (degree_sum == expected_sum)
			else report_mismatch("degree_sum", 128'(degree_sum), 128'(expected_sum));
	endtask

	initial begin
		rstn = 1'b0;
		enabled = 1'b1;
		start = 1'b0;
		first_vertex = '0;
		vertex_count = '0;
		base_address = 64'h0000_0100_0000_0000;
		inject_foreign = 1'b0;
		transfer_id = 0;
		expect_first = '0;
		expect_count = '0;
		repeat (3) @(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		check_idle_outputs();

		run_transfer(16, 8);
		run_transfer(5, 14);
		inject_foreign = 1'b1;
		run_transfer(29, 19);
		inject_foreign = 1'b0;

		// pull enabled in the middle of a transfer
		launch(3, 40);
		wait_for_vertices(4, 200);
		enabled = 1'b0;
		repeat (4) begin
			@(negedge clock);
			check_idle_outputs();
		end
		enabled = 1'b1;
		repeat (2) @(negedge clock);
		run_transfer(3, 11);
		run_transfer(42, 1);

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
common/cu_pkg.sv
rtl/cu_vertex_fetch.sv
cu_cacheline_stream/cu_cacheline_stream.sv
rtl/cu_vertex_drain.sv
rtl/cu_vertex_stream.sv
test/cu_vertex_stream_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module cu_vertex_stream_tb \
	-f src.f -o cu_vertex_stream_sim \
	&& ./obj_dir/cu_vertex_stream_sim \
	|| exit 1
